/* design/icache_cfg_pkg.sv */
// icache configuration
// cache geometry, fetch word size and the cacheable address window,
// plus the widths derived from them

package icache_cfg_pkg;

  // ********************
  // geometry
  // ********************

  localparam int unsigned ADDR_WIDTH = 32;   // physical address
  localparam int unsigned LINE_BYTES = 16;   // bytes per cache line
  localparam int unsigned NUM_SETS   = 64;   // direct mapped, one line per set
  localparam int unsigned WORD_WIDTH = 32;   // fetch word

  localparam int unsigned LINE_WIDTH        = LINE_BYTES * 8;
  localparam int unsigned OFFSET_WIDTH      = $clog2(LINE_BYTES);           // 4
  localparam int unsigned INDEX_WIDTH       = $clog2(NUM_SETS);             // 6
  localparam int unsigned TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH; // 22
  localparam int unsigned WORD_OFFSET_WIDTH = $clog2(WORD_WIDTH / 8);       // byte bits in a word

  // ********************
  // address map
  // ********************

  // one cacheable window, everything else goes around the arrays
  localparam logic [ADDR_WIDTH-1:0] CACHEABLE_BASE = 32'h8000_0000;
  localparam logic [ADDR_WIDTH-1:0] CACHEABLE_SIZE = 32'h4000_0000;

endpackage

/* design/icache_bus_pkg.sv */
// icache port types
// fetch and refill port structs shared by the cache blocks and the bench,
// and the controller state encoding

package icache_bus_pkg;

  import icache_cfg_pkg::*;

  // ********************
  // fetch port
  // ********************

  typedef struct packed {
    logic                  req;        // fetch request, taken when ready is high
    logic                  kill_late;  // drop the fetch in flight
    logic [ADDR_WIDTH-1:0] addr;       // physical fetch address
  } fetch_req_t;

  typedef struct packed {
    logic                  ready;  // can take a fetch this cycle
    logic                  valid;  // one cycle strobe, no back-pressure
    logic [ADDR_WIDTH-1:0] addr;   // address of the answered fetch
    logic [WORD_WIDTH-1:0] data;   // fetched word
  } fetch_rsp_t;

  // ********************
  // refill port
  // ********************

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;  // line aligned, or word aligned when nc
    logic                  nc;     // non-cacheable, line is not kept
  } refill_req_t;

  typedef struct packed {
    logic                  valid;  // single cycle return
    logic [LINE_WIDTH-1:0] line;   // whole line at the line aligned paddr
  } refill_rtn_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,              // waiting for a fetch
    TAG_COMPARE,       // arrays read last cycle, check hit
    WAIT_REFILL_ACK,   // refill request held until memory acks
    WAIT_REFILL_DATA,  // waiting for the line to come back
    DRAIN_KILLED       // fetch killed, swallow the pending return
  } icache_state_e;

endpackage

/* design/icache_tag_array.sv */
// icache tag array
// one tag and valid bit per set; a read registers the entry and
// hit_o compares it against the tag supplied in the following cycle

`timescale 1ns/1ns

module icache_tag_array
  import icache_cfg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_i,     // read the set at index_i
  input  logic                   wr_i,     // allocate the set at index_i
  input  logic [INDEX_WIDTH-1:0] index_i,
  input  logic [TAG_WIDTH-1:0]   tag_i,    // write tag, and compare tag
  output logic                   hit_o
);

  // ********************
  // storage
  // ********************

  logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS];  // tag per set
  logic [NUM_SETS-1:0]  valid_q;             // cleared on reset

  logic                 rd_valid_q;  // valid bit of last read
  logic [TAG_WIDTH-1:0] rd_tag_q;    // tag of last read

  // valid bits, only ever set by an allocation
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (wr_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // ********************
  // read port
  // ********************

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else if (rd_i) begin
      rd_valid_q <= valid_q[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rd_tag_q <= tag_mem[index_i];  // entry seen in TAG_COMPARE
    end
  end

  assign hit_o = rd_valid_q && (rd_tag_q == tag_i);

endmodule

/* design/icache_data_array.sv */
// icache data array
// one line per set, written as a whole line on allocation,
// read through an output register

`timescale 1ns/1ns

module icache_data_array
  import icache_cfg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rd_i,     // read strobe, line shows up next cycle
  input  logic                   wr_i,     // full line write
  input  logic [INDEX_WIDTH-1:0] index_i,
  input  logic [LINE_WIDTH-1:0]  wdata_i,
  output logic [LINE_WIDTH-1:0]  rdata_o
);

  // ********************
  // line storage
  // ********************

  logic [LINE_WIDTH-1:0] line_mem [NUM_SETS];
  logic [LINE_WIDTH-1:0] rdata_q;  // holds until the next read

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      line_mem[index_i] <= wdata_i;  // no partial writes
    end
  end

  // read and write never share a cycle, the controller keeps them apart
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_q <= line_mem[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* design/icache_ctrl.sv */
// icache controller
// accepts fetches, drives the tag and data arrays, issues line or word
// refills, allocates cacheable lines and answers with the selected word

`timescale 1ns/1ns

module icache_ctrl
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,           // low forces bypass
  input  fetch_req_t             fetch_req_i,
  output fetch_rsp_t             fetch_rsp_o,
  output logic                   miss_o,             // perf counter pulse
  output logic                   refill_data_req_o,
  output refill_req_t            refill_req_o,
  input  logic                   refill_ack_i,
  input  refill_rtn_t            refill_rtn_i,
  output logic                   tag_rd_o,
  output logic                   tag_wr_o,
  output logic [INDEX_WIDTH-1:0] index_o,
  output logic [TAG_WIDTH-1:0]   tag_o,
  input  logic                   hit_i,
  output logic                   data_rd_o,
  output logic                   data_wr_o,
  input  logic [LINE_WIDTH-1:0]  line_i
);

  icache_state_e state_q, state_d;

  logic [ADDR_WIDTH-1:0] addr_q, addr_d;  // accepted fetch address
  logic                  bypass_q, bypass_d;
  logic                  kill_q, kill_d;  // kill seen while waiting for ack
  logic                  bypass_in;       // incoming fetch is non-cacheable
  logic                  accept;
  logic                  killed;
  logic [LINE_WIDTH-1:0] sel_line;
  logic [OFFSET_WIDTH-WORD_OFFSET_WIDTH-1:0] word_idx;

  // single window compare, addresses below the base wrap to a large offset
  function automatic logic in_cacheable(input logic [ADDR_WIDTH-1:0] a);
    logic [ADDR_WIDTH-1:0] rel;
    rel = a - CACHEABLE_BASE;
    return rel < CACHEABLE_SIZE;
  endfunction

  // ********************
  // request path
  // ********************

  assign accept    = fetch_rsp_o.ready & fetch_req_i.req;
  assign bypass_in = ~enable_i | ~in_cacheable(fetch_req_i.addr);
  assign addr_d    = accept ? fetch_req_i.addr : addr_q;  // arrays index the incoming fetch
  assign bypass_d  = accept ? bypass_in : bypass_q;
  assign killed    = fetch_req_i.kill_late | kill_q;

  assign index_o = addr_d[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag_o   = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];  // compare and allocate both use addr_q

  // line aligned for cacheable, word aligned for bypass
  assign refill_req_o.nc    = bypass_d;
  assign refill_req_o.paddr = bypass_d ?
      {addr_d[ADDR_WIDTH-1:WORD_OFFSET_WIDTH], {WORD_OFFSET_WIDTH{1'b0}}} :
      {addr_d[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

  // ********************
  // word select
  // ********************

  assign sel_line = (state_q == TAG_COMPARE) ? line_i : refill_rtn_i.line;
  assign word_idx = addr_q[OFFSET_WIDTH-1:WORD_OFFSET_WIDTH];

  assign fetch_rsp_o.addr = addr_q;
  assign fetch_rsp_o.data = sel_line[word_idx*WORD_WIDTH +: WORD_WIDTH];
  assign data_wr_o        = tag_wr_o;  // allocation writes both arrays
  assign data_rd_o        = tag_rd_o;  // data read alongside the tag, hit assumed

  // ********************
  // fsm
  // ********************

  always_comb begin
    state_d           = state_q;
    kill_d            = kill_q;
    fetch_rsp_o.ready = 1'b0;
    fetch_rsp_o.valid = 1'b0;
    miss_o            = 1'b0;
    refill_data_req_o = 1'b0;
    tag_rd_o          = 1'b0;
    tag_wr_o          = 1'b0;

    case (state_q)
      IDLE: begin
        fetch_rsp_o.ready = 1'b1;
      end
      TAG_COMPARE: begin
        if (fetch_req_i.kill_late) begin
          fetch_rsp_o.ready = 1'b1;  // dropped, no refill
        end else if (hit_i) begin
          fetch_rsp_o.valid = 1'b1;
          fetch_rsp_o.ready = 1'b1;
        end else begin
          miss_o            = 1'b1;
          refill_data_req_o = 1'b1;
          state_d = refill_ack_i ? WAIT_REFILL_DATA : WAIT_REFILL_ACK;
        end
      end
      WAIT_REFILL_ACK: begin
        refill_data_req_o = 1'b1;  // held with a stable paddr
        if (fetch_req_i.kill_late) kill_d = 1'b1;
        if (refill_ack_i) state_d = WAIT_REFILL_DATA;
      end
      WAIT_REFILL_DATA: begin
        if (killed) begin
          if (refill_rtn_i.valid) fetch_rsp_o.ready = 1'b1;  // drop it, ready at once
          else                    state_d = DRAIN_KILLED;
        end else if (refill_rtn_i.valid) begin
          fetch_rsp_o.valid = 1'b1;
          if (bypass_q) begin
            fetch_rsp_o.ready = 1'b1;  // nothing to write back
          end else begin
            tag_wr_o = 1'b1;
            state_d  = IDLE;  // one idle cycle after allocation
          end
        end
      end
      DRAIN_KILLED: begin
        if (refill_rtn_i.valid) fetch_rsp_o.ready = 1'b1;  // discard the line
      end
      default: state_d = IDLE;
    endcase

    // any ready cycle may take the next fetch
    if (fetch_rsp_o.ready) begin
      state_d = IDLE;
      kill_d  = 1'b0;
      if (fetch_req_i.req) begin
        if (bypass_in) begin
          refill_data_req_o = 1'b1;  // straight to memory, arrays untouched
          state_d = refill_ack_i ? WAIT_REFILL_DATA : WAIT_REFILL_ACK;
        end else begin
          tag_rd_o = 1'b1;
          state_d  = TAG_COMPARE;
        end
      end
    end
  end

  // ********************
  // registers
  // ********************

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      bypass_q <= 1'b0;
      kill_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      bypass_q <= bypass_d;
      kill_q   <= kill_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;  // payload, only read while a fetch is in flight
  end

endmodule

/* design/icache_top.sv */
// icache top
// direct mapped instruction cache: controller plus tag and data arrays,
// one fetch port and one refill port

`timescale 1ns/1ns

module icache_top
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        enable_i,
  input  fetch_req_t  fetch_req_i,
  output fetch_rsp_t  fetch_rsp_o,
  output logic        miss_o,
  output logic        refill_data_req_o,
  output refill_req_t refill_req_o,
  input  logic        refill_ack_i,
  input  refill_rtn_t refill_rtn_i
);

  logic                   tag_rd, tag_wr;     // tag array strobes
  logic                   data_rd, data_wr;   // data array strobes
  logic [INDEX_WIDTH-1:0] index;              // shared set index
  logic [TAG_WIDTH-1:0]   tag;
  logic                   hit;
  logic [LINE_WIDTH-1:0]  line;               // registered array line

  // ********************
  // controller
  // ********************

  icache_ctrl u_icache_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .enable_i          (enable_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_rsp_o       (fetch_rsp_o),
    .miss_o            (miss_o),
    .refill_data_req_o (refill_data_req_o),
    .refill_req_o      (refill_req_o),
    .refill_ack_i      (refill_ack_i),
    .refill_rtn_i      (refill_rtn_i),
    .tag_rd_o          (tag_rd),
    .tag_wr_o          (tag_wr),
    .index_o           (index),
    .tag_o             (tag),
    .hit_i             (hit),
    .data_rd_o         (data_rd),
    .data_wr_o         (data_wr),
    .line_i            (line)
  );

  // ********************
  // arrays
  // ********************

  icache_tag_array u_icache_tag_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rd_i    (tag_rd),
    .wr_i    (tag_wr),
    .index_i (index),
    .tag_i   (tag),
    .hit_o   (hit)
  );

  icache_data_array u_icache_data_array (
    .clk_i   (clk_i),
    .rd_i    (data_rd),
    .wr_i    (data_wr),
    .index_i (index),
    .wdata_i (refill_rtn_i.line),  // allocation takes the refill line as is
    .rdata_o (line)
  );

endmodule

/* bench/tb_clkgen.sv */
// testbench clock and reset
// 10 ns clock, active low reset held for 3 cycles

`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // released away from the active edge
  end

endmodule

/* bench/refill_mem_model.sv */
// refill memory model
// answers each refill after a random ack delay and a random return delay
// line content follows word(A) = A ^ 32'h5A5A_0000

`timescale 1ns/1ns

module refill_mem_model
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        refill_data_req_i,
  input  refill_req_t refill_req_i,
  output logic        refill_ack_o,
  output refill_rtn_t refill_rtn_o,
  output int          refill_count_o,  // refills acked so far
  output logic [31:0] last_paddr_o,
  output logic        last_nc_o        // nc flag of the last acked refill
);

  // whole line at the line aligned address
  function automatic logic [LINE_WIDTH-1:0] line_at(input logic [31:0] paddr);
    logic [LINE_WIDTH-1:0] l;
    logic [31:0]           base;
    base = {paddr[31:4], 4'h0};
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = (base + 32'(w * 4)) ^ 32'h5A5A_0000;
    end
    return l;
  endfunction

  initial begin
    logic [31:0] paddr;
    logic        nc;
    int          ack_dly;
    int          ret_dly;
    refill_ack_o   = 1'b0;
    refill_rtn_o   = '0;
    refill_count_o = 0;
    last_paddr_o   = '0;
    last_nc_o      = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && refill_data_req_i) begin
        paddr   = refill_req_i.paddr;  // held stable until ack
        nc      = refill_req_i.nc;
        ack_dly = int'($urandom_range(3, 0));
        repeat (ack_dly) @(negedge clk_i);
        refill_ack_o   = 1'b1;
        refill_count_o = refill_count_o + 1;
        last_paddr_o   = paddr;
        last_nc_o      = nc;
        @(negedge clk_i);
        refill_ack_o = 1'b0;
        ret_dly = int'($urandom_range(6, 1));
        repeat (ret_dly - 1) @(negedge clk_i);
        refill_rtn_o.valid = 1'b1;  // single cycle return
        refill_rtn_o.line  = line_at(paddr);
        @(negedge clk_i);
        refill_rtn_o = '0;
      end
    end
  end

endmodule

/* bench/icache_asserts.sv */
// icache protocol assertions
// bound into icache_top to check the fetch strobe and refill handshake

`timescale 1ns/1ns

module icache_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        req_i,          // fetch request
  input logic        ready_i,
  input logic        valid_i,        // response strobe
  input logic        miss_i,
  input logic        refill_req_i,   // refill_data_req_o
  input logic        ack_i,
  input logic [31:0] paddr_i
);

  // ********************
  // fetch side
  // ********************

  // without a new accept the strobe must drop
  valid_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !(ready_i && req_i) |=> !valid_i)
    else $error("valid held for a second cycle");

  // a miss pulse only follows an accept and never comes with a response
  miss_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_i |-> $past(ready_i && req_i) && !valid_i)
    else $error("miss pulse without a preceding accept or with a response");

  // ********************
  // refill side
  // ********************

  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req_i && !ack_i |=> refill_req_i && $stable(paddr_i))
    else $error("refill request dropped or moved before ack");

endmodule

/* bench/icache_tb.sv */
// icache testbench
// table driven fetches against the cache with a random latency memory
// expected data and refill counts come from the content rule and a tag model

`timescale 1ns/1ns

module icache_tb
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
();

  localparam int NUM_DIR  = 13;                 // directed rows
  localparam int NUM_RND  = 24;                 // random rows
  localparam int NUM_ROWS = NUM_DIR + NUM_RND;

  logic        clk, rst_n, enable;
  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  logic        miss, refill_data_req, refill_ack;
  refill_req_t refill_req;
  refill_rtn_t refill_rtn;
  int          refill_count;
  logic [31:0] last_paddr;
  logic        last_nc;

  // ********************
  // stimulus table
  // ********************
  string       row_name  [NUM_ROWS];
  logic [31:0] row_addr  [NUM_ROWS];
  logic        row_en    [NUM_ROWS];
  int          row_kill  [NUM_ROWS];  // kill cycle after accept or 0 for none
  int          row_delta [NUM_ROWS];  // refills expected
  int          row_miss  [NUM_ROWS];
  int          row_rsp   [NUM_ROWS];

  logic        pred_valid [NUM_SETS];  // bench side tag model
  logic [21:0] pred_tag   [NUM_SETS];
  int          err_count, rows_ok, rows_bad;

  tb_clkgen u_tb_clkgen (.clk_o(clk), .rst_no(rst_n));

  icache_top u_icache_top (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable),
    .fetch_req_i(fetch_req), .fetch_rsp_o(fetch_rsp), .miss_o(miss),
    .refill_data_req_o(refill_data_req), .refill_req_o(refill_req),
    .refill_ack_i(refill_ack), .refill_rtn_i(refill_rtn)
  );

  refill_mem_model u_refill_mem_model (
    .clk_i(clk), .rst_ni(rst_n), .refill_data_req_i(refill_data_req),
    .refill_req_i(refill_req), .refill_ack_o(refill_ack), .refill_rtn_o(refill_rtn),
    .refill_count_o(refill_count), .last_paddr_o(last_paddr), .last_nc_o(last_nc)
  );

  bind icache_top icache_asserts u_icache_asserts (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(fetch_req_i.req),
    .ready_i(fetch_rsp_o.ready), .valid_i(fetch_rsp_o.valid), .miss_i(miss_o),
    .refill_req_i(refill_data_req_o), .ack_i(refill_ack_i), .paddr_i(refill_req_o.paddr)
  );

  function automatic logic is_bypass(input logic [31:0] a, input logic en);
    return !en || a < 32'h8000_0000 || a >= 32'hC000_0000;
  endfunction

  function automatic void add_row(input int r, input string n, input logic [31:0] a,
                                  input logic en, input int k, input int d, input int m,
                                  input int rsp);
    row_name[r]  = n;
    row_addr[r]  = a;
    row_en[r]    = en;
    row_kill[r]  = k;
    row_delta[r] = d;
    row_miss[r]  = m;
    row_rsp[r]   = rsp;
  endfunction

  // walks one row through the tag model and allocates only on a live miss
  // the expectations are written back only when fill is set
  function automatic void predict(input int r, input bit fill);
    int          idx;
    logic [21:0] t;
    int          d;
    int          m;
    int          rsp;
    idx = int'(row_addr[r][9:4]);
    t   = row_addr[r][31:10];
    if (is_bypass(row_addr[r], row_en[r])) begin
      d   = 1;
      m   = 0;
      rsp = 1;
    end else if (pred_valid[idx] && pred_tag[idx] == t) begin
      d   = 0;
      m   = 0;
      rsp = 1;
    end else begin
      d   = 1;
      m   = 1;
      rsp = (row_kill[r] == 0) ? 1 : 0;
      if (row_kill[r] == 0) begin
        pred_valid[idx] = 1'b1;
        pred_tag[idx]   = t;
      end
    end
    if (fill) begin
      row_delta[r] = d;
      row_miss[r]  = m;
      row_rsp[r]   = rsp;
    end
  endfunction

  task automatic build_table();
    int          sel;
    logic [31:0] a;
    add_row(0,  "miss_first",      32'h8000_1004, 1, 0, 1, 1, 1);
    add_row(1,  "hit_same",        32'h8000_100C, 1, 0, 0, 0, 1);
    add_row(2,  "bypass_disabled", 32'h8000_1008, 0, 0, 1, 0, 1);
    add_row(3,  "bypass_dis_again",32'h8000_1008, 0, 0, 1, 0, 1);
    add_row(4,  "bypass_low",      32'h0000_2006, 1, 0, 1, 0, 1);
    add_row(5,  "bypass_low_again",32'h0000_2006, 1, 0, 1, 0, 1);
    add_row(6,  "conflict_a",      32'h8000_2010, 1, 0, 1, 1, 1);
    add_row(7,  "conflict_b",      32'h8000_2410, 1, 0, 1, 1, 1);  // same index
    add_row(8,  "conflict_a2",     32'h8000_2014, 1, 0, 1, 1, 1);
    add_row(9,  "conflict_b2",     32'h8000_241C, 1, 0, 1, 1, 1);
    add_row(10, "kill_refill",     32'h8000_3020, 1, 2, 1, 1, 0);  // kill while refilling
    add_row(11, "after_kill",      32'h8000_3024, 1, 0, 1, 1, 1);
    add_row(12, "hit_after_kill",  32'h8000_3028, 1, 0, 0, 0, 1);
    for (int s = 0; s < NUM_SETS; s++) pred_valid[s] = 1'b0;
    for (int r = 0; r < NUM_DIR; r++) predict(r, 1'b0);  // only to train the model
    // 8 lines where pairs of them share an index
    for (int r = NUM_DIR; r < NUM_ROWS; r++) begin
      sel = int'($urandom_range(7, 0));
      a   = 32'h8004_0000 + 32'((sel % 4) * 16) + 32'((sel / 4) * 1024);
      a   = a + 32'($urandom_range(3, 0) * 4);
      add_row(r, $sformatf("random_%0d", r - NUM_DIR), a, 1, 0, 0, 0, 0);
      predict(r, 1'b1);
    end
  endtask

  // ********************
  // checking
  // ********************
  task automatic check(input string name, input string what,
                       input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s %s expected %h actual %h", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic run_row(input int r);
    int          cyc, base_cnt, n_valid, valid_cyc, miss_seen, errs_before;
    logic        done;
    logic [31:0] rsp_data, rsp_addr, a;
    errs_before = err_count;
    base_cnt    = refill_count;
    a           = row_addr[r];
    @(negedge clk);
    enable              = row_en[r];
    fetch_req.req       = 1'b1;
    fetch_req.addr      = a;
    fetch_req.kill_late = 1'b0;
    #1;
    if (!fetch_rsp.ready) begin
      $display("%s: cache not ready when the fetch was offered", row_name[r]);
      err_count++;
    end
    cyc       = 0;
    n_valid   = 0;
    valid_cyc = 0;
    miss_seen = 0;
    done      = 1'b0;
    rsp_data  = '0;
    rsp_addr  = '0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      fetch_req.req       = 1'b0;
      fetch_req.kill_late = (row_kill[r] == cyc);
      #1;
      if (miss) miss_seen = 1;
      if (fetch_rsp.valid) begin
        n_valid++;
        valid_cyc = cyc;
        rsp_data  = fetch_rsp.data;
        rsp_addr  = fetch_rsp.addr;
      end
      done = fetch_rsp.ready;  // back to taking fetches
    end
    check(row_name[r], "refills", row_delta[r], refill_count - base_cnt);
    check(row_name[r], "miss pulse", row_miss[r], miss_seen);
    check(row_name[r], "responses", row_rsp[r], n_valid);
    if (row_rsp[r] != 0 && n_valid != 0) begin
      check(row_name[r], "data", {a[31:2], 2'b00} ^ 32'h5A5A_0000, rsp_data);
      check(row_name[r], "rsp addr", a, rsp_addr);
      if (row_delta[r] == 0) check(row_name[r], "hit latency", 1, valid_cyc);
    end
    if (row_delta[r] != 0) begin
      check(row_name[r], "nc", is_bypass(a, row_en[r]), last_nc);
      if (is_bypass(a, row_en[r])) check(row_name[r], "paddr", {a[31:2], 2'b00}, last_paddr);
      else                         check(row_name[r], "paddr", {a[31:4], 4'h0}, last_paddr);
    end
    if (err_count == errs_before) begin
      rows_ok++;
      $display("%s: passed", row_name[r]);
    end else begin
      rows_bad++;
      $display("%s: failed", row_name[r]);
    end
  endtask

  // ********************
  // main and watchdog
  // ********************
  initial begin
    void'($urandom(32'h531b15d3));
    enable    = 1'b0;
    fetch_req = '0;
    err_count = 0;
    rows_ok   = 0;
    rows_bad  = 0;
    build_table();
    wait (rst_n === 1'b1);
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    $display("rows passed %0d, rows failed %0d, errors %0d", rows_ok, rows_bad, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * 40) @(posedge clk);
    $display("Timeout: the fetch sequence did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* verilog.f */
design/icache_cfg_pkg.sv
design/icache_bus_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
bench/tb_clkgen.sv
bench/refill_mem_model.sv
bench/icache_asserts.sv
bench/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module icache_tb \
  -f verilog.f \
  -o Vicache_tb

./obj_dir/Vicache_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  exit 1
fi
